/* hdl/channel_mac.sv */
`timescale 1ns/1ns
`default_nettype none

module channel_mac (
	input  logic                                 clk,
	input  logic                                 rst,
	input  logic                                 en,
	input  conv_pkg::window_t                    window,
	input  conv_pkg::pixel_t [conv_pkg::TAPS-1:0] weights,
	input  conv_pkg::data_t                      bias,
	output conv_pkg::data_t                      result
);

	localparam int TAPS   = conv_pkg::TAPS;
	localparam int IN_CH  = conv_pkg::IN_CH;
	localparam int N_PROD = TAPS * IN_CH;
	localparam int LEVELS = $clog2(N_PROD + 1);  // Products plus the bias.
	localparam int LEAVES = 1 << LEVELS;
	localparam int BASE   = LEAVES - 1;          // Index of the first leaf.

	// Heap ordered tree, node n sums nodes 2n+1 and 2n+2.
	conv_pkg::data_t sum [2 * LEAVES - 1];

	always_comb
	begin
		for (int t = 0; t < TAPS; t++)
		begin
			sum[BASE + t * IN_CH]     = window[t].ch0 * weights[t].ch0;
			sum[BASE + t * IN_CH + 1] = window[t].ch1 * weights[t].ch1;
			sum[BASE + t * IN_CH + 2] = window[t].ch2 * weights[t].ch2;
		end
		sum[BASE + N_PROD] = bias;
		for (int i = BASE + N_PROD + 1; i < 2 * LEAVES - 1; i++)
		begin
			sum[i] = '0;                         // Padding leaves.
		end
		for (int n = BASE - 1; n >= 0; n--)
		begin
			sum[n] = sum[2 * n + 1] + sum[2 * n + 2];
		end
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			result <= '0;
		end
		else if (en)
		begin
			result <= sum[0];
		end
	end

endmodule

`default_nettype wire

/* hdl/coef_loader.sv */
`timescale 1ns/1ns
`default_nettype none

module coef_loader #(
	parameter type payload_t = conv_pkg::data_t,
	parameter int  DEPTH     = 8
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 start,
	input  payload_t             load_data,
	output payload_t [DEPTH-1:0] bank
);

	localparam int CW = $clog2(DEPTH + 1);

	logic          loading;
	logic [CW-1:0] count;                        // Words shifted in so far.
	logic          shift;

	assign shift = start | loading;

	// ########################################################################
	// Load control
	// ########################################################################

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			loading <= 1'b0;
			count   <= '0;
		end
		else if (start)
		begin
			loading <= (DEPTH > 1);              // First word goes in with start.
			count   <= CW'(1);
		end
		else if (loading)
		begin
			loading <= (count != CW'(DEPTH - 1));
			count   <= count + 1'b1;
		end
	end

	// Shift chain, new words enter at the top and the first ends at index 0.
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			bank <= '0;
		end
		else if (shift)
		begin
			for (int i = 0; i < DEPTH - 1; i++)
			begin
				bank[i] <= bank[i + 1];
			end
			bank[DEPTH-1] <= load_data;
		end
	end

endmodule

`default_nettype wire

/* hdl/conv_layer_top.sv */
`timescale 1ns/1ns
`default_nettype none

module conv_layer_top #(
	parameter int WIDTH  = 32,
	parameter int HEIGHT = 32,
	parameter int OUT_CH = 8
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 weight_start,
	input  conv_pkg::pixel_t     weight_data,
	input  logic                 bias_start,
	input  conv_pkg::data_t      bias_data,
	input  logic                 frame_start,
	input  conv_pkg::pixel_t     pixel,
	output logic                 out_valid,
	output logic [15:0]          out_row,
	output logic [15:0]          out_col,
	output logic [OUT_CH*16-1:0] out_data,
	output logic                 frame_done
);

	localparam int TAPS = conv_pkg::TAPS;

	conv_pkg::pixel_t [OUT_CH*TAPS-1:0] weight_bank;  // Channel k at k*TAPS.
	conv_pkg::data_t  [OUT_CH-1:0]      bias_bank;
	conv_pkg::window_t                  window;
	logic                               mac_en;

	// ########################################################################
	// Coefficient banks
	// ########################################################################

	coef_loader #(
		.payload_t (conv_pkg::pixel_t),
		.DEPTH     (OUT_CH * TAPS)
	) weight_loader_i (
		.clk       (clk),
		.rst       (rst),
		.start     (weight_start),
		.load_data (weight_data),
		.bank      (weight_bank)
	);

	coef_loader #(
		.payload_t (conv_pkg::data_t),
		.DEPTH     (OUT_CH)
	) bias_loader_i (
		.clk       (clk),
		.rst       (rst),
		.start     (bias_start),
		.load_data (bias_data),
		.bank      (bias_bank)
	);

	// ########################################################################
	// Datapath
	// ########################################################################

	window_buffer #(
		.WIDTH  (WIDTH)
	) window_i (
		.clk    (clk),
		.rst    (rst),
		.pixel  (pixel),
		.window (window)
	);

	for (genvar k = 0; k < OUT_CH; k++)
	begin : mac_g
		channel_mac mac_i (
			.clk     (clk),
			.rst     (rst),
			.en      (mac_en),
			.window  (window),
			.weights (weight_bank[k*TAPS +: TAPS]),
			.bias    (bias_bank[k]),
			.result  (out_data[k*16 +: 16])
		);
	end

	output_sequencer #(
		.WIDTH       (WIDTH),
		.HEIGHT      (HEIGHT)
	) sequencer_i (
		.clk         (clk),
		.rst         (rst),
		.frame_start (frame_start),
		.mac_en      (mac_en),
		.out_valid   (out_valid),
		.out_row     (out_row),
		.out_col     (out_col),
		.frame_done  (frame_done)
	);

endmodule

`default_nettype wire

/* hdl/conv_pkg.sv */
`default_nettype none

package conv_pkg;

	// ########################################################################
	// Geometry
	// ########################################################################

	localparam int IN_CH  = 3;                   // Input channels per pixel.
	localparam int KERNEL = 3;                   // Window side.
	localparam int TAPS   = KERNEL * KERNEL;     // Taps per window.

	// ########################################################################
	// Data types
	// ########################################################################

	typedef logic signed [15:0] data_t;          // Sample, weight, bias or result.

	// One pixel with all input channels, or one tap's weights.
	typedef struct packed {
		data_t ch2;
		data_t ch1;
		data_t ch0;
	} pixel_t;

	// Tap number is row * KERNEL + column, tap 0 is the oldest pixel.
	typedef pixel_t [TAPS-1:0] window_t;

endpackage

`default_nettype wire

/* hdl/output_sequencer.sv */
`timescale 1ns/1ns
`default_nettype none

module output_sequencer #(
	parameter int WIDTH  = 32,
	parameter int HEIGHT = 32
) (
	input  logic        clk,
	input  logic        rst,
	input  logic        frame_start,
	output logic        mac_en,
	output logic        out_valid,
	output logic [15:0] out_row,
	output logic [15:0] out_col,
	output logic        frame_done
);

	localparam int EDGE = conv_pkg::KERNEL - 1;  // Rows and columns before a full window.

	typedef enum logic {IDLE, RUN} state_t;

	// Output address of the window just completed.
	typedef struct packed {
		logic [15:0] row;
		logic [15:0] col;
		logic        last;
	} tag_t;

	state_t      state;
	logic [15:0] row;                            // Position of the pixel now on the input.
	logic [15:0] col;
	logic        hit;
	logic        last_pix;
	tag_t        tag_q;

	assign hit      = (state == RUN) && (row >= 16'(EDGE)) && (col >= 16'(EDGE));
	assign last_pix = (row == 16'(HEIGHT - 1)) && (col == 16'(WIDTH - 1));

	// ########################################################################
	// Position counters and strobes
	// ########################################################################

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state      <= IDLE;
			row        <= '0;
			col        <= '0;
			mac_en     <= 1'b0;
			out_valid  <= 1'b0;
			frame_done <= 1'b0;
		end
		else
		begin
			out_valid  <= mac_en;
			frame_done <= mac_en & tag_q.last;
			mac_en     <= hit & ~frame_start;
			if (frame_start)
			begin
				state <= RUN;                    // Pixel (0,0) is captured now.
				row   <= '0;
				col   <= 16'd1;
			end
			else if (state == RUN)
			begin
				if (last_pix)
				begin
					state <= IDLE;
				end
				if (col == 16'(WIDTH - 1))
				begin
					col <= '0;
					row <= row + 1'b1;
				end
				else
				begin
					col <= col + 1'b1;
				end
			end
		end
	end

	// Address follows the MAC pipeline.
	always_ff @(posedge clk)
	begin
		tag_q.row  <= row - 16'(EDGE);
		tag_q.col  <= col - 16'(EDGE);
		tag_q.last <= last_pix;
		if (mac_en)
		begin
			out_row <= tag_q.row;
			out_col <= tag_q.col;
		end
	end

endmodule

`default_nettype wire

/* hdl/window_buffer.sv */
`timescale 1ns/1ns
`default_nettype none

module window_buffer #(
	parameter int WIDTH = 32
) (
	input  logic              clk,
	input  logic              rst,
	input  conv_pkg::pixel_t  pixel,
	output conv_pkg::window_t window
);

	localparam int K        = conv_pkg::KERNEL;
	localparam int LINE_LEN = WIDTH - K;         // Stages between two window rows.

	// Line r carries pixels from window row r + 1 up to window row r.
	conv_pkg::pixel_t line_q [K-1][LINE_LEN];

	// ########################################################################
	// Line delays
	// ########################################################################

	always_ff @(posedge clk)
	begin
		for (int r = 0; r < K - 1; r++)
		begin
			line_q[r][0] <= window[(r + 1) * K]; // Leftmost tap of the row below.
			for (int s = 1; s < LINE_LEN; s++)
			begin
				line_q[r][s] <= line_q[r][s - 1];
			end
		end
	end

	// ########################################################################
	// Window registers
	// ########################################################################

	// Each row shifts left by one tap per pixel.
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			window <= '0;
		end
		else
		begin
			for (int r = 0; r < K; r++)
			begin
				for (int c = 0; c < K - 1; c++)
				begin
					window[r * K + c] <= window[r * K + c + 1];
				end
			end
			for (int r = 0; r < K - 1; r++)
			begin
				window[r * K + K - 1] <= line_q[r][LINE_LEN - 1];
			end
			window[K * K - 1] <= pixel;          // Newest pixel, lower right.
		end
	end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Compile and run the conv layer testbench with Verilator.
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing -Wno-fatal --top-module conv_layer_tb -f sources.f \
	-o conv_layer_sim > build.log 2>&1 \
	&& ./obj_dir/conv_layer_sim > sim.log 2>&1 \
	|| { echo "build or run failed, see build.log and sim.log"; exit 1; }
cat sim.log
grep -q "ALL CHECKS PASSED" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }

/* sources.f */
hdl/conv_pkg.sv
hdl/coef_loader.sv
hdl/window_buffer.sv
hdl/channel_mac.sv
hdl/output_sequencer.sv
hdl/conv_layer_top.sv
tests/conv_layer_tb.sv

/* tests/conv_layer_patterns.txt */
// Hex words. Weights and pixels are {ch2,ch1,ch0}, 16 bits each.
// Results are {k3,k2,k1,k0}, output channel 0 in the low 16 bits.

// Weights, one output channel per line, taps 0 to 8.
@00
000000000000 000000000000 000000000000 000000000000 000000000001 000000000000 000000000000 000000000000 000000000000
0000ffff0000 0000ffff0001 0000ffff0002 0000ffff0003 0000ffff0004 0000ffff0005 0000ffff0006 0000ffff0007 0000ffff0008
000300000000 000000000000 000000050000 000000000000 000000000000 000000000000 00000000fffe 000000000000 fffe00000000
000100010001 000100010001 000100010001 000100010001 000100010001 000100010001 000100010001 000100010001 000100010001

// Biases, channels 0 to 3, first set then the reload set.
@24
0010 fff0 0064 0003
ffff 0005 0000 03e8

// Frame 1 pixels, one image row per line. ch0 = 6r+c, ch1 = r+1, ch2 = c-2.
@2c
fffe00010000 ffff00010001 000000010002 000100010003 000200010004 000300010005
fffe00020006 ffff00020007 000000020008 000100020009 00020002000a 00030002000b
fffe0003000c ffff0003000d 00000003000e 00010003000f 000200030010 000300030011
fffe00040012 ffff00040013 000000040014 000100040015 000200040016 000300040017
fffe00050018 ffff00050019 00000005001a 00010005001b 00020005001c 00030005001d

// Frame 2 pixels. ch0 = 30-6r-c, ch1 = 2c, ch2 = r-1.
@4a
ffff0000001e ffff0002001d ffff0004001c ffff0006001b ffff0008001a ffff000a0019
000000000018 000000020017 000000040016 000000060015 000000080014 0000000a0013
000100000012 000100020011 000100040010 00010006000f 00010008000e 0001000a000d
00020000000c 00020002000b 00020004000a 000200060009 000200080008 0002000a0007
000300000006 000300020005 000300040004 000300060003 000300080002 0003000a0001

// Frame 1 results, one output row per line.
@68
004b004b014c0017 005d004a01700018 006f004901940019 0081004801b8001a
008a0044021b001d 009c0043023f001e 00ae00420263001f 00c0004102870020
00c9003d02ea0023 00db003c030e0024 00ed003b03320025 00ff003a03560026

// Frame 2 results, after the bias reload.
@74
04c9ffeb02bd0016 04d2fff702870015 04db000302510014 04e4000f021b0013
049cfff801e50010 04a5000401af000f 04ae00100179000e 04b7001c0143000d
046f0005010d000a 0478001100d70009 0481001d00a10008 048a0029006b0007

/* tests/conv_layer_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module conv_layer_tb;

	localparam int WIDTH      = 6;
	localparam int HEIGHT     = 5;
	localparam int OUT_CH     = 4;
	localparam int PERIOD     = 40;
	localparam int RST_CYCLES = 10;
	localparam int MAX_GAP    = 8;
	localparam int OUT_W      = WIDTH - 2;
	localparam int N_OUT      = OUT_W * (HEIGHT - 2);
	localparam int N_PIX      = WIDTH * HEIGHT;
	localparam int N_WEIGHT   = OUT_CH * 9;
	localparam int W_BASE     = 0;
	localparam int B_BASE     = W_BASE + N_WEIGHT;      // Two bias sets.
	localparam int P_BASE     = B_BASE + 2 * OUT_CH;    // Two frames of pixels.
	localparam int E_BASE     = P_BASE + 2 * N_PIX;     // Two frames of results.
	localparam int N_PAT      = E_BASE + 2 * N_OUT;
	localparam int RUN_CYCLES = RST_CYCLES + N_WEIGHT + 2 * OUT_CH + 2 * (N_PIX + 4) + 6 * MAX_GAP;
	localparam int TIMEOUT_NS = 2 * RUN_CYCLES * PERIOD;
	localparam string PAT_FILE = "tests/conv_layer_patterns.txt";

	// Window completed by one captured pixel.
	typedef struct packed {
		logic [31:0] edge_n;                     // Edge that must raise out_valid.
		logic [15:0] row;
		logic [15:0] col;
	} expect_t;

	logic                 clk;
	logic                 rst;
	logic                 weight_start;
	conv_pkg::pixel_t     weight_data;
	logic                 bias_start;
	conv_pkg::data_t      bias_data;
	logic                 frame_start;
	conv_pkg::pixel_t     pixel;
	logic                 out_valid;
	logic [15:0]          out_row;
	logic [15:0]          out_col;
	logic [OUT_CH*16-1:0] out_data;
	logic                 frame_done;

	logic [63:0] pat_mem [N_PAT];
	logic [31:0] edge_n = '0;
	logic        feeding;
	logic [15:0] feed_row;
	logic [15:0] feed_col;
	expect_t     expect_q [$];
	int          frame_idx;
	int          out_idx;
	int          out_total;
	int          done_count;
	logic        done_seen;
	int          value_errors;
	int          proto_errors;
	string       test_name;

	conv_layer_top #(
		.WIDTH  (WIDTH),
		.HEIGHT (HEIGHT),
		.OUT_CH (OUT_CH)
	) dut_i (
		.clk          (clk),
		.rst          (rst),
		.weight_start (weight_start),
		.weight_data  (weight_data),
		.bias_start   (bias_start),
		.bias_data    (bias_data),
		.frame_start  (frame_start),
		.pixel        (pixel),
		.out_valid    (out_valid),
		.out_row      (out_row),
		.out_col      (out_col),
		.out_data     (out_data),
		.frame_done   (frame_done)
	);

	always #(PERIOD / 2) clk = ~clk;

	always @(posedge clk)
	begin
		edge_n <= edge_n + 32'd1;
	end

	task automatic report_mismatch(string what, logic [63:0] expected, logic [63:0] actual);
		$display("error %s %s: expected %0h actual %0h", test_name, what, expected, actual);
		value_errors++;
	endtask

	// ########################################################################
	// Output monitor
	// ########################################################################

	always @(negedge clk)
	begin
		expect_t head;
		expect_t item;
		if (rst)
		begin
			if (out_valid !== 1'b0 || frame_done !== 1'b0)
			begin
				$display("out_valid or frame_done not low during reset at %0t", $time);
				proto_errors++;
			end
		end
		else
		begin
			if (out_valid)
			begin
				if (done_seen)
				begin
					$display("out_valid after frame_done in %s", test_name);
					proto_errors++;
				end
				if (expect_q.size() == 0)
				begin
					$display("out_valid without a completed window at edge %0d", edge_n);
					proto_errors++;
				end
				else
				begin
					head = expect_q.pop_front();
					if (edge_n != head.edge_n)
						report_mismatch("output edge", head.edge_n, edge_n);
					if (out_row != head.row)
						report_mismatch("out_row", head.row, out_row);
					if (out_col != head.col)
						report_mismatch("out_col", head.col, out_col);
					if (out_idx < N_OUT && out_data !== pat_mem[E_BASE + frame_idx * N_OUT + out_idx])
						report_mismatch("out_data", pat_mem[E_BASE + frame_idx * N_OUT + out_idx],
							out_data);
				end
				out_idx++;
				out_total++;
			end
			else if (expect_q.size() != 0 && expect_q[0].edge_n == edge_n)
			begin
				$display("no output for window (%0d,%0d) in %s", expect_q[0].row, expect_q[0].col,
					test_name);
				proto_errors++;
				head = expect_q.pop_front();
			end
			if (frame_done)
			begin
				if (!out_valid || done_seen)
				begin
					$display("frame_done not paired with the last out_valid in %s", test_name);
					proto_errors++;
				end
				if (out_idx != N_OUT)
					report_mismatch("outputs before frame_done", N_OUT, out_idx);
				done_seen = 1'b1;
				done_count++;
			end
			// Pixel on the input now is captured at the next edge.
			if (feeding && feed_row >= 16'd2 && feed_col >= 16'd2)
			begin
				item.edge_n = edge_n + 32'd2;
				item.row    = feed_row - 16'd2;
				item.col    = feed_col - 16'd2;
				expect_q.push_back(item);
			end
		end
	end

	// ########################################################################
	// Stimulus
	// ########################################################################

	task automatic idle_gap();
		int unsigned n;
		n = 1 + ($urandom % MAX_GAP);
		repeat (n) @(posedge clk);
	endtask

	task automatic load_weights();
		for (int i = 0; i < N_WEIGHT; i++)
		begin
			@(posedge clk);
			weight_start <= (i == 0);
			weight_data  <= pat_mem[W_BASE + i][47:0];
		end
		@(posedge clk);
		weight_start <= 1'b0;
		weight_data  <= '0;
	endtask

	task automatic load_biases(int set);
		for (int i = 0; i < OUT_CH; i++)
		begin
			@(posedge clk);
			bias_start <= (i == 0);
			bias_data  <= pat_mem[B_BASE + set * OUT_CH + i][15:0];
		end
		@(posedge clk);
		bias_start <= 1'b0;
		bias_data  <= '0;
	endtask

	task automatic run_frame(int frame);
		frame_idx = frame;
		out_idx   = 0;
		done_seen = 1'b0;
		test_name = $sformatf("frame %0d", frame + 1);
		for (int i = 0; i < N_PIX; i++)
		begin
			@(posedge clk);
			frame_start <= (i == 0);
			pixel       <= pat_mem[P_BASE + frame * N_PIX + i][47:0];
			feeding     <= 1'b1;
			feed_row    <= 16'(i / WIDTH);
			feed_col    <= 16'(i % WIDTH);
		end
		@(posedge clk);
		frame_start <= 1'b0;
		pixel       <= '0;
		feeding     <= 1'b0;
		while (done_count < frame + 1)
			@(negedge clk);
	endtask

	initial
	begin
		void'($urandom(32'h4cd6));
		$readmemh(PAT_FILE, pat_mem);
		clk          = 1'b0;
		rst          = 1'b1;
		weight_start = 1'b0;
		weight_data  = '0;
		bias_start   = 1'b0;
		bias_data    = '0;
		frame_start  = 1'b0;
		pixel        = '0;
		feeding      = 1'b0;
		feed_row     = '0;
		feed_col     = '0;
		frame_idx    = 0;
		out_idx      = 0;
		out_total    = 0;
		done_count   = 0;
		done_seen    = 1'b0;
		value_errors = 0;
		proto_errors = 0;
		test_name    = "reset";
		repeat (RST_CYCLES) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		if (out_valid !== 1'b0 || frame_done !== 1'b0)
		begin
			$display("out_valid or frame_done not low after reset");
			proto_errors++;
		end
		idle_gap();
		load_weights();
		idle_gap();
		load_biases(0);
		idle_gap();
		run_frame(0);
		idle_gap();
		load_biases(1);                          // Weights stay as loaded.
		idle_gap();
		run_frame(1);
		repeat (2 * MAX_GAP) @(negedge clk);
		test_name = "summary";
		if (expect_q.size() != 0)
		begin
			$display("%0d completed windows produced no output", expect_q.size());
			proto_errors++;
		end
		if (done_count != 2)
			report_mismatch("frame_done count", 2, done_count);
		if (out_total != 2 * N_OUT)
			report_mismatch("output count", 2 * N_OUT, out_total);
		$display("value errors %0d, protocol errors %0d", value_errors, proto_errors);
		if (value_errors == 0 && proto_errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

	// Watchdog.
	initial
	begin
		#(TIMEOUT_NS);
		$display("timeout after %0d ns with %0d frames done", TIMEOUT_NS, done_count);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire
